//--- Makefile
VERILATOR  := verilator
TOP        := chip_tb
FILELIST   := chip_top.f
MDIR       := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: build
	./$(MDIR)/V$(TOP) $(RUN_FLAGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)

//--- chip_top.f
logic/chip_pkg.sv
logic/cpu_reset_stretch.sv
logic/lane_fifo.sv
logic/channel_hub.sv
logic/link_port.sv
logic/chip_top.sv
verification/chip_assertions.sv
verification/chip_tb.sv

//--- logic/channel_hub.sv
`timescale 1ns/1ps
`default_nettype none

module channel_hub import chip_pkg::*; #(
  parameter int TX_DEPTH = 8,  // host to link lane
  parameter int RX_DEPTH = 8   // link to host lane
) (
  input  wire          CPU_CLK,
  input  wire          RST,          // stretched CPU reset, active low
  // host side
  input  wire          tx_push,
  input  word_t        tx_word,
  output logic         tx_full,
  input  wire          rx_pop,
  output logic         rx_valid,
  output word_t        rx_word,
  input  wire          len_wr,       // load frame_len
  input  frame_len_t   frame_len,
  // link side
  output word_t        send_word,
  output logic         send_valid,
  input  wire          send_pop,     // link took the head word
  input  word_t        recv_word,
  input  wire          recv_wr,      // word arrived from the line
  output logic         rx_room,
  input  wire          frame_done,
  input  link_status_t link_stat,
  output frame_len_t   frame_len_q,
  input  wire          overrun,
  // errors and interrupt
  output logic         err,
  input  wire          err_ack,
  output logic         irq,
  output link_status_t status
);

  logic rx_full;  // receive lane has no slot left

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel 0 lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  lane_fifo #(
    .DEPTH     (TX_DEPTH)
  ) tx_lane_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (tx_push),
    .push_word (tx_word),
    .pop       (send_pop),
    .head_word (send_word),
    .valid     (send_valid),
    .full      (tx_full)
  );

  lane_fifo #(
    .DEPTH     (RX_DEPTH)
  ) rx_lane_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (recv_wr),
    .push_word (recv_word),
    .pop       (rx_pop),
    .head_word (rx_word),
    .valid     (rx_valid),
    .full      (rx_full)
  );

  assign rx_room = !rx_full;  // link drops words while low

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      frame_len_q <= '0;          // zero keeps irq quiet
      irq         <= 1'b0;
      status      <= '0;
      err         <= 1'b0;
    end else begin
      if (len_wr) begin
        frame_len_q <= frame_len;
      end
      irq <= frame_done;          // one cycle behind the link
      if (frame_done) begin
        status <= link_stat;      // snapshot held until the next frame
      end
      // sticky overrun, a new overrun beats the ack
      if (overrun) begin
        err <= 1'b1;
      end else if (err_ack) begin
        err <= 1'b0;
      end
    end
  end

endmodule : channel_hub

`default_nettype wire

//--- logic/chip_pkg.sv
`default_nettype none

// shared types for the chip shell
package chip_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] word_t;       // one host word, either direction
  typedef logic [15:0] frame_len_t;  // frame length counted in words

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // serial link framing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // line rests low between words
  localparam logic LINK_START_BIT = 1'b1;       // marks the start of a word

  // data bits that follow each start bit, MSB first
  localparam int unsigned LINK_WORD_BITS = 32;  // same as word_t

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // link snapshot at the end of each frame, host reads it with irq
  typedef struct packed {
    logic       irq_vld;     // a frame has finished since reset
    frame_len_t words_seen;  // words counted into that frame
  } link_status_t;

endpackage : chip_pkg

`default_nettype wire

//--- logic/chip_top.sv
`timescale 1ns/1ps
`default_nettype none

module chip_top import chip_pkg::*; #(
  parameter int RESET_STRETCH = 16,
  parameter int TX_DEPTH      = 8,
  parameter int RX_DEPTH      = 8
) (
  input  wire          CPU_CLK,
  input  wire          RST,        // active low
  // host channel 0
  input  wire          tx_push,
  input  word_t        tx_word,
  output logic         tx_full,
  input  wire          rx_pop,
  output logic         rx_valid,
  output word_t        rx_word,
  input  wire          len_wr,
  input  frame_len_t   frame_len,
  output logic         irq,
  output link_status_t status,
  output logic         err,
  input  wire          err_ack,
  // serial line
  input  wire          line_rx,
  output logic         line_tx,
  output logic         cpu_ready
);

  logic         cpu_rst;      // stretched, active low
  word_t        send_word;
  logic         send_valid;
  logic         send_pop;
  word_t        recv_word;
  logic         recv_wr;
  logic         rx_room;
  logic         frame_done;
  link_status_t link_stat;
  frame_len_t   frame_len_q;
  logic         overrun;

  cpu_reset_stretch #(
    .RESET_STRETCH (RESET_STRETCH)
  ) reset_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .cpu_rst   (cpu_rst),
    .cpu_ready (cpu_ready)
  );

  channel_hub #(
    .TX_DEPTH (TX_DEPTH),
    .RX_DEPTH (RX_DEPTH)
  ) hub_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (cpu_rst),
    .tx_push     (tx_push),
    .tx_word     (tx_word),
    .tx_full     (tx_full),
    .rx_pop      (rx_pop),
    .rx_valid    (rx_valid),
    .rx_word     (rx_word),
    .len_wr      (len_wr),
    .frame_len   (frame_len),
    .send_word   (send_word),
    .send_valid  (send_valid),
    .send_pop    (send_pop),
    .recv_word   (recv_word),
    .recv_wr     (recv_wr),
    .rx_room     (rx_room),
    .frame_done  (frame_done),
    .link_stat   (link_stat),
    .frame_len_q (frame_len_q),
    .overrun     (overrun),
    .err         (err),
    .err_ack     (err_ack),
    .irq         (irq),
    .status      (status)
  );

  link_port link_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (cpu_rst),
    .send_word   (send_word),
    .send_valid  (send_valid),
    .send_pop    (send_pop),
    .recv_word   (recv_word),
    .recv_wr     (recv_wr),
    .rx_room     (rx_room),
    .frame_len_q (frame_len_q),
    .frame_done  (frame_done),
    .link_stat   (link_stat),
    .overrun     (overrun),
    .line_tx     (line_tx),
    .line_rx     (line_rx)
  );

endmodule : chip_top

`default_nettype wire

//--- logic/cpu_reset_stretch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_reset_stretch #(
  parameter int RESET_STRETCH = 16  // cycles the CPU side stays in reset
) (
  input  wire  CPU_CLK,
  input  wire  RST,        // board reset, active low
  output logic cpu_rst,    // stretched reset, active low
  output logic cpu_ready   // high once the stretch has run out
);

  localparam int CNT_W = $clog2(RESET_STRETCH + 1);

  logic [CNT_W-1:0] stretch_cnt;  // cycles seen since RST went high

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      stretch_cnt <= '0;
      cpu_ready   <= 1'b0;
    end else begin
      if (stretch_cnt != CNT_W'(RESET_STRETCH)) begin
        stretch_cnt <= stretch_cnt + 1'b1;  // saturates at the limit
      end
      // one more edge after the limit, ready lands on cycle RESET_STRETCH
      cpu_ready <= (stretch_cnt == CNT_W'(RESET_STRETCH));
    end
  end

  assign cpu_rst = cpu_ready;  // released together with ready

endmodule : cpu_reset_stretch

`default_nettype wire

//--- logic/lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lane_fifo import chip_pkg::*; #(
  parameter int DEPTH = 8  // words held
) (
  input  wire   CPU_CLK,
  input  wire   RST,        // active low
  input  wire   push,       // ignored while full
  input  word_t push_word,
  input  wire   pop,        // ignored while empty
  output word_t head_word,  // shown ahead of pop
  output logic  valid,      // head_word holds data
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_t            mem [DEPTH];  // storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // words held
  logic             do_push;
  logic             do_pop;

  // circular pointer step
  function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && valid;

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_step(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_step(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end  // both or neither keeps the count
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  assign head_word = mem[rd_ptr];               // show-ahead read
  assign valid     = (count != '0);
  assign full      = (count == CNT_W'(DEPTH));

endmodule : lane_fifo

`default_nettype wire

//--- logic/link_port.sv
`timescale 1ns/1ps
`default_nettype none

module link_port import chip_pkg::*; (
  input  wire          CPU_CLK,
  input  wire          RST,          // stretched CPU reset, active low
  // hub side
  input  word_t        send_word,
  input  wire          send_valid,
  output logic         send_pop,     // head word taken this cycle
  output word_t        recv_word,
  output logic         recv_wr,
  input  wire          rx_room,
  input  frame_len_t   frame_len_q,
  output logic         frame_done,
  output link_status_t link_stat,
  output logic         overrun,
  // line side
  output logic         line_tx,
  input  wire          line_rx
);

  localparam int CNT_W = $clog2(LINK_WORD_BITS + 1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit serializer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic             tx_busy;  // start bit or data on the line
  logic [CNT_W-1:0] tx_cnt;   // data bits sent so far
  word_t            tx_sh;    // MSB goes out next

  assign send_pop = send_valid && !tx_busy;

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
      line_tx <= ~LINK_START_BIT;         // idle level
    end else if (send_pop) begin
      tx_busy <= 1'b1;
      tx_cnt  <= '0;
      line_tx <= LINK_START_BIT;          // cycle after the pop
    end else if (tx_busy) begin
      if (tx_cnt == CNT_W'(LINK_WORD_BITS)) begin
        tx_busy <= 1'b0;                  // last bit done
        line_tx <= ~LINK_START_BIT;       // guaranteed idle gap
      end else begin
        tx_cnt  <= tx_cnt + 1'b1;
        line_tx <= tx_sh[LINK_WORD_BITS-1];
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (send_pop) begin
      tx_sh <= send_word;
    end else if (tx_busy) begin
      tx_sh <= {tx_sh[LINK_WORD_BITS-2:0], 1'b0};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive deserializer and frame count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic             rx_busy;    // shifting data bits
  logic [CNT_W-1:0] rx_cnt;     // data bits taken so far
  word_t            rx_sh;
  logic             rx_last;    // final data sample this cycle
  frame_len_t       word_cnt;   // words kept in the current frame
  frame_len_t       word_nxt;
  logic             frame_end;  // this word closes the frame

  assign rx_last   = rx_busy && (rx_cnt == CNT_W'(LINK_WORD_BITS - 1));
  assign word_nxt  = word_cnt + 1'b1;
  // >= also closes a frame if the length was lowered mid-frame
  assign frame_end = (frame_len_q != '0) && (word_nxt >= frame_len_q);

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rx_busy    <= 1'b0;
      rx_cnt     <= '0;
      word_cnt   <= '0;
      recv_wr    <= 1'b0;
      overrun    <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      recv_wr    <= 1'b0;                 // strobes default low
      overrun    <= 1'b0;
      frame_done <= 1'b0;
      if (!rx_busy) begin
        if (line_rx == LINK_START_BIT) begin
          rx_busy <= 1'b1;                // start bit seen
          rx_cnt  <= '0;
        end
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
        if (rx_last) begin
          rx_busy <= 1'b0;
          if (rx_room) begin
            recv_wr    <= 1'b1;
            frame_done <= frame_end;
            word_cnt   <= frame_end ? '0 : word_nxt;
          end else begin
            overrun <= 1'b1;              // word dropped, not counted
          end
        end
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (rx_busy) begin
      rx_sh <= {rx_sh[LINK_WORD_BITS-2:0], line_rx};
    end
    if (rx_last && rx_room && frame_end) begin
      link_stat.irq_vld    <= 1'b1;
      link_stat.words_seen <= word_nxt;
    end
  end

  assign recv_word = rx_sh;  // holds until the next start bit

endmodule : link_port

`default_nettype wire

//--- verification/chip_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module chip_assertions #(
  parameter int RESET_STRETCH = 16  // must match the bound chip_top
) (
  input wire CPU_CLK,
  input wire RST,        // board reset, active low
  input wire cpu_ready,
  input wire line_tx,
  input wire irq,
  input wire err,
  input wire err_ack,
  input wire overrun,    // internal link strobe
  input wire rx_valid,
  input wire tx_full
);

  int          since_rst = 0;  // edges seen with RST high, saturating
  int unsigned fail_cnt  = 0;  // failed checks so far

  always @(posedge CPU_CLK) begin
    if (!RST) begin
      since_rst <= 0;
    end else if (since_rst < RESET_STRETCH + 2) begin
      since_rst <= since_rst + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset release
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ready_early_a: assert property (@(posedge CPU_CLK)
      (RST && since_rst <= RESET_STRETCH) |-> !cpu_ready)
    else begin
      fail_cnt++;
      $error("cpu_ready came up before the reset stretch ran out");
    end

  ready_late_a: assert property (@(posedge CPU_CLK)
      $rose(cpu_ready) |-> (since_rst == RESET_STRETCH + 1))
    else begin
      fail_cnt++;
      $error("cpu_ready rose %0d cycles after reset release", since_rst - 1);
    end

  // outputs quiet until the CPU side is out of reset
  quiet_in_reset_a: assert property (@(posedge CPU_CLK)
      (RST && !cpu_ready) |-> (!line_tx && !irq && !err && !rx_valid && !tx_full))
    else begin
      fail_cnt++;
      $error("an output was active while cpu_ready was still low");
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // interrupt and error latch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  irq_pulse_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
      irq |=> !irq)
    else begin
      fail_cnt++;
      $error("irq stayed high for two cycles in a row");
    end

  err_set_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
      overrun |=> err)
    else begin
      fail_cnt++;
      $error("err did not rise the cycle after an overrun");
    end

  err_hold_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
      (err && !err_ack) |=> err)
    else begin
      fail_cnt++;
      $error("err dropped without an acknowledge");
    end

  err_clear_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
      (err_ack && !overrun) |=> !err)
    else begin
      fail_cnt++;
      $error("err still high the cycle after err_ack");
    end

  err_cause_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
      (!err && !overrun) |=> !err)
    else begin
      fail_cnt++;
      $error("err rose without an overrun");
    end

endmodule : chip_assertions

bind chip_top chip_assertions #(
  .RESET_STRETCH (RESET_STRETCH)
) chk_i (
  .CPU_CLK   (CPU_CLK),
  .RST       (RST),
  .cpu_ready (cpu_ready),
  .line_tx   (line_tx),
  .irq       (irq),
  .err       (err),
  .err_ack   (err_ack),
  .overrun   (overrun),
  .rx_valid  (rx_valid),
  .tx_full   (tx_full)
);

`default_nettype wire

//--- verification/chip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chip_tb import chip_pkg::*; ();

  localparam int RESET_STRETCH   = 16;
  localparam int TX_DEPTH        = 8;
  localparam int RX_DEPTH        = 8;
  localparam int FRAME_WORDS     = 5;
  localparam int BURST_WORDS     = 20;
  localparam int TOTAL_WORDS     = 2 * BURST_WORDS + RX_DEPTH + 2 + 1;  // all tests
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 500;

  logic         CPU_CLK;
  logic         RST;
  logic         tx_push;
  word_t        tx_word;
  logic         tx_full;
  logic         rx_pop;
  logic         rx_valid;
  word_t        rx_word;
  logic         len_wr;
  frame_len_t   frame_len;
  logic         irq;
  link_status_t status;
  logic         err;
  logic         err_ack;
  logic         line_rx;
  logic         line_tx;
  logic         cpu_ready;

  logic  loop_sel;          // high loops line_tx into line_rx
  logic  drive_rx;          // line level when not looped
  word_t rng_state;
  word_t expected_q[$];     // words still owed by rx_word
  int    irq_cnt     = 0;
  int    overrun_cnt = 0;

  assign line_rx = loop_sel ? line_tx : drive_rx;

  initial CPU_CLK = 1'b0;
  always #10 CPU_CLK = ~CPU_CLK;  // 20 ns period

  chip_top #(
    .RESET_STRETCH (RESET_STRETCH),
    .TX_DEPTH      (TX_DEPTH),
    .RX_DEPTH      (RX_DEPTH)
  ) dut_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .tx_push   (tx_push),
    .tx_word   (tx_word),
    .tx_full   (tx_full),
    .rx_pop    (rx_pop),
    .rx_valid  (rx_valid),
    .rx_word   (rx_word),
    .len_wr    (len_wr),
    .frame_len (frame_len),
    .irq       (irq),
    .status    (status),
    .err       (err),
    .err_ack   (err_ack),
    .line_rx   (line_rx),
    .line_tx   (line_tx),
    .cpu_ready (cpu_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic apply_reset();
    RST = 1'b0;
    repeat (5) @(negedge CPU_CLK);      // 5 rising edges in reset
    RST = 1'b1;
    while (!cpu_ready) @(negedge CPU_CLK);
  endtask

  task automatic set_frame_len(input frame_len_t len);
    len_wr    = 1'b1;
    frame_len = len;
    @(negedge CPU_CLK);
    len_wr    = 1'b0;
  endtask

  task automatic push_host_word(input word_t w);
    while (tx_full) @(negedge CPU_CLK); // held pushes would be ignored
    tx_push = 1'b1;
    tx_word = w;
    expected_q.push_back(w);
    @(negedge CPU_CLK);
    tx_push = 1'b0;
  endtask

  task automatic push_random(input int n);
    repeat (n) begin
      rng_state = xorshift32(rng_state);
      push_host_word(rng_state);
    end
  endtask

  task automatic pop_and_check();
    word_t exp_w;
    while (!rx_valid) @(negedge CPU_CLK);
    if (expected_q.size() == 0) begin
      fail_run("a word arrived on rx_word that was never sent");
    end
    exp_w = expected_q.pop_front();
    if (rx_word !== exp_w) begin
      fail_run($sformatf("ERROR rx_word expected %h actual %h", exp_w, rx_word));
    end
    rx_pop = 1'b1;
    @(negedge CPU_CLK);
    rx_pop = 1'b0;
  endtask

  task automatic loop_words(input int n);
    fork
      push_random(n);
      repeat (n) pop_and_check();
    join
  endtask

  // start bit then MSB first at one bit per cycle
  task automatic drive_line_word(input word_t w);
    loop_sel = 1'b0;
    drive_rx = LINK_START_BIT;
    @(negedge CPU_CLK);
    for (int i = LINK_WORD_BITS - 1; i >= 0; i--) begin
      drive_rx = w[i];
      @(negedge CPU_CLK);
    end
    drive_rx = ~LINK_START_BIT;         // back to idle
    expected_q.push_back(w);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitors and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge CPU_CLK) begin
    if (irq) begin
      irq_cnt++;
      if (status.irq_vld !== 1'b1) begin
        fail_run($sformatf("ERROR status.irq_vld expected %h actual %h", 1'b1,
                           status.irq_vld));
      end
      if (status.words_seen !== frame_len_t'(FRAME_WORDS)) begin
        fail_run($sformatf("ERROR status.words_seen expected %h actual %h",
                           frame_len_t'(FRAME_WORDS), status.words_seen));
      end
    end
    if (dut_i.overrun) begin
      overrun_cnt++;                    // internal link strobe
    end
    if (dut_i.chk_i.fail_cnt != 0) begin
      fail_run("a bound assertion on chip_top failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CPU_CLK);
    fail_run($sformatf("timeout, the run did not finish within %0d cycles",
                       WATCHDOG_CYCLES));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int irq_base;
    int ov_base;
    RST       = 1'b0;
    tx_push   = 1'b0;
    tx_word   = '0;
    rx_pop    = 1'b0;
    len_wr    = 1'b0;
    frame_len = '0;
    err_ack   = 1'b0;
    loop_sel  = 1'b1;
    drive_rx  = ~LINK_START_BIT;
    rng_state = 32'd72581;

    apply_reset();                      // release timing checked by bound checks

    // frames first so the word counter starts from zero
    set_frame_len(frame_len_t'(FRAME_WORDS));
    irq_base = irq_cnt;
    loop_words(BURST_WORDS);
    if (irq_cnt - irq_base != BURST_WORDS / FRAME_WORDS) begin
      fail_run($sformatf("ERROR irq expected %h pulses actual %h",
                         BURST_WORDS / FRAME_WORDS, irq_cnt - irq_base));
    end

    loop_words(BURST_WORDS);            // plain loopback with prompt pops

    // hold off pops until the receive lane overflows twice
    ov_base = overrun_cnt;
    push_random(RX_DEPTH + 2);
    while (overrun_cnt < ov_base + 2) @(negedge CPU_CLK);
    @(negedge CPU_CLK);                 // let the last overrun strobe pass
    if (err !== 1'b1) begin
      fail_run($sformatf("ERROR err expected %h actual %h", 1'b1, err));
    end
    err_ack = 1'b1;
    @(negedge CPU_CLK);
    err_ack = 1'b0;
    if (err !== 1'b0) begin
      fail_run($sformatf("ERROR err expected %h actual %h", 1'b0, err));
    end
    repeat (RX_DEPTH) pop_and_check();
    expected_q.delete();                // the two dropped words
    if (rx_valid !== 1'b0) begin
      fail_run("the receive lane kept words that should have been dropped");
    end

    // one word straight onto the receive wire
    rng_state = xorshift32(rng_state);
    drive_line_word(rng_state);
    pop_and_check();

    @(negedge CPU_CLK);
    if (dut_i.chk_i.fail_cnt != 0) begin
      fail_run("a bound assertion on chip_top failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule : chip_tb

`default_nettype wire
